//--- vlog.f
+incdir+hw
+incdir+dv
hw/slide_pkg.sv
hw/vrf_pkg.sv
hw/slide_insn_queue.sv
hw/slide_result_fifo.sv
hw/slide_engine.sv
hw/slide_unit.sv
dv/slide_unit_tb.sv

//--- dv/slide_cases.txt
// op sew vl stride vd id stall words, all hex, one case per line
// op 0 slide-up 1 slide-down; sew 0..3 is 8..64 bit; stall 0 none .. 3 heavy
// Slide-up at each element width
0 0 0028 0003 0010 0 0 0002
0 1 0032 0005 0020 1 1 0004
0 2 0014 0009 0030 2 0 0002
0 3 000c 0004 0040 3 2 0002
// Slide-down, aligned and unaligned offsets
1 0 0040 0000 0050 4 0 0002
1 0 002d 0007 0060 5 1 0002
1 1 0021 0010 0070 6 0 0003
1 2 000a 0003 0080 7 3 0002
1 3 0005 0009 0090 0 0 0002
// Offset past the vector, nothing written
0 0 0020 0020 00a0 1 0 0000
// Single-word vectors
0 0 0001 0000 00b0 2 1 0001
1 3 0004 0000 00c0 3 0 0001
0 1 0010 0001 00d0 4 2 0001
// Longer vectors
1 0 0064 0021 0100 5 0 0004
0 2 0040 0011 0120 6 1 0006
1 2 0040 0011 0140 7 3 0008
0 3 0008 0001 0160 0 0 0002
1 1 0007 0064 0170 1 2 0001
0 0 00c8 0041 0180 2 1 0005
1 0 001f 0001 01a0 3 0 0001
0 2 0009 0002 01b0 4 0 0002
1 3 0010 0005 01c0 5 2 0004
0 1 0028 0027 01d0 6 0 0001
1 2 0003 0001 01e0 7 1 0001
// Word-aligned offsets
0 0 0060 0000 0200 0 0 0003
1 0 0060 0040 0210 1 3 0003
// Only the top word is written
0 3 0003 0002 0220 2 0 0001
1 1 0014 000c 0230 3 1 0002
0 2 001e 001d 0240 4 0 0001
1 3 0001 0003 0250 5 0 0001

//--- dv/slide_tb_checks.svh
`ifndef SLIDE_TB_CHECKS_SVH
`define SLIDE_TB_CHECKS_SVH

// One Fibonacci step, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// Next n random bits, the LFSR steps once per bit
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v          = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// Result word, data compared only on enabled bytes
task automatic check_result(input result_t got, input result_t exp);
  word_t mask;
  mask = '0;
  for (int b = 0; b < WB; b++) begin
    if (exp.be[b]) begin
      mask[8*b +: 8] = 8'hff;
    end
  end
  if (got.addr !== exp.addr) begin
    res_errs++;
    $display("** Error at %0t: result_o.addr is %h, expected %h", $time, got.addr, exp.addr);
  end
  if (got.be !== exp.be) begin
    res_errs++;
    $display("** Error at %0t: result_o.be is %h, expected %h", $time, got.be, exp.be);
  end
  if ((got.wdata & mask) !== (exp.wdata & mask)) begin
    res_errs++;
    $display("** Error at %0t: result_o.wdata is %h, expected %h", $time,
             got.wdata & mask, exp.wdata & mask);
  end
endtask

// Completion report
task automatic check_resp(input slide_resp_t got, input slide_resp_t exp);
  if (got !== exp) begin
    resp_errs++;
    $display("** Error at %0t: resp_o is done %b id %0d, expected done %b id %0d",
             $time, got.done, got.id, exp.done, exp.id);
  end
endtask

// Single handshake or status bit
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    flag_errs++;
    $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

//--- dv/slide_unit_tb.sv
`timescale 1ns/1ps
`include "slide_defs.svh"

module slide_unit_tb;
  import slide_pkg::*;
  import vrf_pkg::*;

  localparam int          WB        = `SLIDE_WORD_BYTES;
  localparam int          MAX_CASES = 64;
  localparam logic [31:0] LFSR_SEED = 32'h84a24c0c;

  logic        clk_i;
  logic        rst_ni;
  slide_req_t  req_i;
  logic        req_valid_i;
  logic        req_ready_o;
  slide_resp_t resp_o;
  operand_t    operand_i;
  logic        operand_valid_i;
  logic        operand_ready_o;
  result_t     result_o;
  logic        result_valid_o;
  logic        result_ready_i;

  // Eight hex fields per case, see the data file
  logic [31:0] case_mem [8*MAX_CASES];
  // Source vector bytes of the case being built
  logic [7:0]  src_mem [2048];

  // Stimulus and expected streams, all in acceptance order
  slide_req_t  reqs[$];
  word_t       ops[$];
  result_t     exp_res[$];
  slide_resp_t exp_resp[$];
  int          exp_words[$];
  int          stall_lvl[$];

  logic [31:0] lfsr_state;
  int          res_errs;
  int          resp_errs;
  int          flag_errs;
  int          misc_errs;
  int          n_cases;
  int          total_words;
  int          cyc_cnt;
  int          cyc_limit;
  int          req_idx;
  int          op_idx;
  int          acc_cnt;
  int          done_cnt;
  int          got_words;
  int          stall_now;
  logic [31:0] gap;
  logic        op_taken;
  logic        running;

  `include "slide_tb_checks.svh"

  slide_unit dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_o          (resp_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_o        (result_o),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Case table and byte model
  ////////////////////////////////////////////////////////////

  task automatic load_cases();
    // Unused slots carry a marker that no op field can hold
    for (int i = 0; i < 8 * MAX_CASES; i++) begin
      case_mem[i] = {16'hffff, 16'(i)};
    end
    $readmemh("dv/slide_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_mem[8*n_cases] <= 32'd1) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      misc_errs++;
      $display("No test case could be read from the data file");
    end
  endtask

  task automatic build_case(input int c);
    slide_req_t  req;
    slide_resp_t rsp;
    result_t     r;
    word_t       wd;
    int          n;
    int          off;
    int          first_b;
    int          last_b;
    int          j;
    int          s;
    int          words;
    logic        hit;
    req.op     = slide_op_e'(case_mem[8*c][0]);
    req.sew    = vew_e'(case_mem[8*c+1][1:0]);
    req.vl     = vlen_t'(case_mem[8*c+2]);
    req.stride = vlen_t'(case_mem[8*c+3]);
    req.vd     = vaddr_t'(case_mem[8*c+4]);
    req.id     = vid_t'(case_mem[8*c+5]);
    // Vector size and offset in bytes
    n   = int'(req.vl) * (1 << req.sew);
    off = int'(req.stride) * (1 << req.sew);
    // Source bytes that the slide reads
    if (req.op == OP_SLIDEUP) begin
      first_b = 0;
      last_b  = n - off - 1;
    end else begin
      first_b = off;
      last_b  = off + n - 1;
    end
    // Whole source words are fed, first one from floor(first_b / 32)
    if (last_b >= first_b) begin
      for (int w = first_b / WB; w <= last_b / WB; w++) begin
        for (int b = 0; b < WB; b++) begin
          src_mem[WB*w + b] = 8'(rand_bits(8));
          wd[8*b +: 8]      = src_mem[WB*w + b];
        end
        ops.push_back(wd);
      end
    end
    // Destination words, emitted only if some byte is written
    words = 0;
    for (int w = 0; w < (n + WB - 1) / WB; w++) begin
      r = '0;
      for (int b = 0; b < WB; b++) begin
        j = WB * w + b;
        if (req.op == OP_SLIDEUP) begin
          hit = (j >= off) && (j < n);
          s   = j - off;
        end else begin
          hit = (j < n);
          s   = j + off;
        end
        if (hit) begin
          r.be[b]            = 1'b1;
          r.wdata[8*b +: 8]  = src_mem[s];
        end
      end
      if (r.be != '0) begin
        r.addr = req.vd + vaddr_t'(w);
        exp_res.push_back(r);
        words++;
      end
    end
    if (words != int'(case_mem[8*c+7])) begin
      misc_errs++;
      $display("Case %0d: byte model gives %0d result words, data file says %0d",
               c, words, case_mem[8*c+7]);
    end
    rsp.done = 1'b1;
    rsp.id   = req.id;
    reqs.push_back(req);
    exp_resp.push_back(rsp);
    exp_words.push_back(words);
    stall_lvl.push_back(int'(case_mem[8*c+6]));
    total_words += int'(case_mem[8*c+7]);
  endtask

  task automatic report_counts();
    $display("Errors: result %0d, resp %0d, flag %0d, other %0d",
             res_errs, resp_errs, flag_errs, misc_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Drive, 1 ns after the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    if (running) begin
      // Requests go out back to back
      req_valid_i = (req_idx < n_cases);
      if (req_idx < n_cases) begin
        req_i = reqs[req_idx];
      end
      // An offered word stays until taken, gaps only between words
      if (!operand_valid_i || op_taken) begin
        gap             = rand_bits(2);
        operand_valid_i = (op_idx < ops.size()) && (gap != 0);
        if (op_idx < ops.size()) begin
          operand_i.data = ops[op_idx];
        end
      end
      // Stall level of the instruction now committing
      stall_now      = (done_cnt < n_cases) ? stall_lvl[done_cnt] : 0;
      result_ready_i = (rand_bits(2) >= stall_now);
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor, sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (running) begin
      // Done closes the words counted so far
      if (resp_o.done) begin
        if (exp_resp.size() == 0) begin
          misc_errs++;
          $display("Done pulse at %0t with no instruction pending", $time);
        end else begin
          check_resp(resp_o, exp_resp.pop_front());
          if (got_words != exp_words[0]) begin
            misc_errs++;
            $display("Instruction %0d reported done after %0d result words, %0d expected",
                     done_cnt, got_words, exp_words[0]);
          end
          void'(exp_words.pop_front());
        end
        got_words = 0;
        done_cnt++;
      end
      if (result_valid_o && result_ready_i) begin
        if (exp_res.size() == 0) begin
          misc_errs++;
          $display("Result word at %0t with none expected", $time);
        end else begin
          check_result(result_o, exp_res.pop_front());
        end
        got_words++;
      end
      // Queue is full exactly when 4 instructions are pending
      check_flag("req_ready_o", req_ready_o,
                 (acc_cnt - done_cnt) < `SLIDE_INSN_DEPTH);
      if (req_valid_i && req_ready_o) begin
        acc_cnt++;
        req_idx++;
      end
      op_taken = operand_valid_i && operand_ready_o;
      if (op_taken) begin
        op_idx++;
      end
    end
  end

  always @(negedge clk_i) begin
    if (running) begin
      cyc_cnt++;
    end
    if (running && cyc_cnt > cyc_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions done",
               cyc_cnt, done_cnt, n_cases);
      report_counts();
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_ready_i  = 1'b0;
    running         = 1'b0;
    op_taken        = 1'b0;
    lfsr_state      = LFSR_SEED;
    res_errs        = 0;
    resp_errs       = 0;
    flag_errs       = 0;
    misc_errs       = 0;
    total_words     = 0;
    cyc_cnt         = 0;
    req_idx         = 0;
    op_idx          = 0;
    acc_cnt         = 0;
    done_cnt        = 0;
    got_words       = 0;
    load_cases();
    for (int c = 0; c < n_cases; c++) begin
      build_case(c);
    end
    cyc_limit = 50 * total_words + 200;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Idle state right after reset
    @(negedge clk_i);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("operand_ready_o", operand_ready_o, 1'b0);
    check_flag("result_valid_o", result_valid_o, 1'b0);
    check_flag("resp_o.done", resp_o.done, 1'b0);
    running = 1'b1;
    wait (done_cnt == n_cases);
    // Let any stray word or done show up
    repeat (10) @(negedge clk_i);
    if (exp_res.size() != 0) begin
      misc_errs++;
      $display("%0d expected result words never appeared", exp_res.size());
    end
    if (op_idx != ops.size()) begin
      misc_errs++;
      $display("%0d source words were never consumed", ops.size() - op_idx);
    end
    report_counts();
    if (res_errs + resp_errs + flag_errs + misc_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hw/slide_unit.sv
`timescale 1ns/1ps
`include "slide_defs.svh"

module slide_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  slide_pkg::slide_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output slide_pkg::slide_resp_t resp_o,
  // Source words from the lanes
  input  vrf_pkg::operand_t      operand_i,
  input  logic                   operand_valid_i,
  output logic                   operand_ready_o,
  // Result words to the lanes
  output vrf_pkg::result_t       result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i
);
  import slide_pkg::*;
  import vrf_pkg::*;

  slide_req_t issue_req;
  logic       issue_valid;
  logic       issue_ready;
  result_t    push_data;
  logic       push_valid;
  logic       push_ready;
  logic       commit_pop;

  // A word leaves the unit on the result handshake
  assign commit_pop = result_valid_o && result_ready_i;

  slide_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_req_o   (issue_req),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready),
    .commit_pop_i  (commit_pop),
    .resp_o        (resp_o)
  );

  slide_engine u_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_ready_o   (issue_ready),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .push_data_o     (push_data),
    .push_valid_o    (push_valid),
    .push_ready_i    (push_ready)
  );

  slide_result_fifo #(
    .payload_t (result_t),
    .DEPTH     (`SLIDE_RESULT_DEPTH)
  ) u_result_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_data_i  (push_data),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .pop_data_o   (result_o),
    .pop_valid_o  (result_valid_o),
    .pop_ready_i  (result_ready_i)
  );

endmodule

//--- hw/slide_engine.sv
`timescale 1ns/1ps
`include "slide_defs.svh"

module slide_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction from the queue
  input  slide_pkg::slide_req_t issue_req_i,
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  // Source words
  input  vrf_pkg::operand_t     operand_i,
  input  logic                  operand_valid_i,
  output logic                  operand_ready_o,
  // Finished words to the result FIFO
  output vrf_pkg::result_t      push_data_o,
  output logic                  push_valid_o,
  input  logic                  push_ready_i
);
  import slide_pkg::*;
  import vrf_pkg::*;

  localparam int unsigned WB         = `SLIDE_WORD_BYTES;
  localparam int unsigned WORD_SHIFT = $clog2(WB);
  localparam int unsigned PNT_W      = WORD_SHIFT + 1;

  typedef logic [PNT_W-1:0] pnt_t;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  // Byte pointers into the source and destination words
  typedef struct packed {
    pnt_t   in_pnt;
    pnt_t   out_pnt;
    vaddr_t vrf;
    vlen_t  left;
  } ctx_t;

  state_e state_d, state_q;
  ctx_t   ctx_d, ctx_q;
  // Destination word under assembly
  word_t  asm_data_d, asm_data_q;
  strb_t  asm_be_d, asm_be_q;

  vlen_t  nbytes;
  vlen_t  off;
  pnt_t   in_room;
  pnt_t   out_room;
  pnt_t   room;
  pnt_t   moved;
  pnt_t   in_nxt;
  pnt_t   out_nxt;
  logic   last;
  logic   run;
  logic   step;
  word_t  merged_data;
  strb_t  merged_be;

  // Vector size and slide offset in bytes
  assign nbytes = issue_req_i.vl << issue_req_i.sew;
  assign off    = issue_req_i.stride << issue_req_i.sew;

  ////////////////////////////////////////////////////////////
  // Byte move
  ////////////////////////////////////////////////////////////

  // Copy whatever fits in both the source rest and the destination rest
  assign in_room  = pnt_t'(WB) - ctx_q.in_pnt;
  assign out_room = pnt_t'(WB) - ctx_q.out_pnt;
  assign room     = (in_room < out_room) ? in_room : out_room;
  assign last     = (ctx_q.left <= vlen_t'(room));
  assign moved    = last ? ctx_q.left[PNT_W-1:0] : room;
  assign in_nxt   = ctx_q.in_pnt + moved;
  assign out_nxt  = ctx_q.out_pnt + moved;

  assign run  = (state_q == ST_RUN) && (ctx_q.left != '0);
  // Stall on a missing operand or a full FIFO
  assign step = run && operand_valid_i && push_ready_i;

  always_comb begin
    int src;
    merged_data = asm_data_q;
    merged_be   = asm_be_q;
    for (int o = 0; o < WB; o++) begin
      src = o - int'(ctx_q.out_pnt) + int'(ctx_q.in_pnt);
      if (o >= int'(ctx_q.out_pnt) && o < int'(out_nxt)) begin
        merged_data[8*o +: 8] = operand_i.data[8*src +: 8];
        merged_be[o]          = 1'b1;
      end
    end
  end

  // Push when the destination word fills or the instruction ends
  assign push_valid_o      = run && operand_valid_i && ((out_nxt == pnt_t'(WB)) || last);
  assign push_data_o.addr  = issue_req_i.vd + ctx_q.vrf;
  assign push_data_o.wdata = merged_data;
  assign push_data_o.be    = merged_be;

  ////////////////////////////////////////////////////////////
  // Slide FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    ctx_d           = ctx_q;
    asm_data_d      = asm_data_q;
    asm_be_d        = asm_be_q;
    issue_ready_o   = 1'b0;
    operand_ready_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (issue_valid_i) begin
          state_d    = ST_RUN;
          asm_data_d = '0;
          asm_be_d   = '0;
          if (issue_req_i.op == OP_SLIDEUP) begin
            // Read from byte 0, write from the offset on
            ctx_d.in_pnt  = '0;
            ctx_d.out_pnt = pnt_t'(off[WORD_SHIFT-1:0]);
            ctx_d.vrf     = vaddr_t'(off >> WORD_SHIFT);
            ctx_d.left    = (off < nbytes) ? nbytes - off : '0;
          end else begin
            // First source word already holds the offset
            ctx_d.in_pnt  = pnt_t'(off[WORD_SHIFT-1:0]);
            ctx_d.out_pnt = '0;
            ctx_d.vrf     = '0;
            ctx_d.left    = nbytes;
          end
        end
      end

      ST_RUN: begin
        if (ctx_q.left == '0) begin
          // Offset past the vector, no byte to write
          state_d       = ST_IDLE;
          issue_ready_o = 1'b1;
        end else if (step) begin
          asm_data_d    = merged_data;
          asm_be_d      = merged_be;
          ctx_d.in_pnt  = in_nxt;
          ctx_d.out_pnt = out_nxt;
          ctx_d.left    = ctx_q.left - vlen_t'(moved);
          // Source word used up
          if ((in_nxt == pnt_t'(WB)) || last) begin
            ctx_d.in_pnt    = '0;
            operand_ready_o = 1'b1;
          end
          if (push_valid_o) begin
            ctx_d.out_pnt = '0;
            ctx_d.vrf     = ctx_q.vrf + 1'b1;
            asm_data_d    = '0;
            asm_be_d      = '0;
          end
          if (last) begin
            state_d       = ST_IDLE;
            issue_ready_o = 1'b1;
          end
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    asm_data_q <= asm_data_d;
    asm_be_q   <= asm_be_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      ctx_q   <= '0;
    end else begin
      state_q <= state_d;
      ctx_q   <= ctx_d;
    end
  end

  // Stalled push keeps its word, relies on a steady operand and instruction
  a_push_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_o && !push_ready_i |=> $stable(push_data_o));

endmodule

//--- hw/slide_result_fifo.sv
`timescale 1ns/1ps
`include "slide_defs.svh"

module slide_result_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `SLIDE_RESULT_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Write side
  input  payload_t push_data_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  // Read side
  output payload_t pop_data_o,
  output logic     pop_valid_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PNT_W-1:0] wr_pnt_q;
  logic [PNT_W-1:0] rd_pnt_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  assign push_ready_o = (cnt_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem_q[rd_pnt_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= (wr_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CNT_W'(DEPTH));

endmodule

//--- hw/slide_insn_queue.sv
`timescale 1ns/1ps
`include "slide_defs.svh"

module slide_insn_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer side
  input  slide_pkg::slide_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Engine side
  output slide_pkg::slide_req_t  issue_req_o,
  output logic                   issue_valid_o,
  input  logic                   issue_ready_i,
  // Result side
  input  logic                   commit_pop_i,
  output slide_pkg::slide_resp_t resp_o
);
  import slide_pkg::*;
  import vrf_pkg::*;

  localparam int unsigned DEPTH      = `SLIDE_INSN_DEPTH;
  localparam int unsigned PNT_W      = $clog2(DEPTH);
  localparam int unsigned CNT_W      = PNT_W + 1;
  localparam int unsigned WORD_SHIFT = $clog2($bits(strb_t));

  // Pointers and counts for the accept, issue and commit phases
  typedef struct packed {
    logic [PNT_W-1:0] accept_pnt;
    logic [PNT_W-1:0] issue_pnt;
    logic [PNT_W-1:0] commit_pnt;
    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] commit_cnt;
  } queue_st_t;

  // Result words written by one instruction
  function automatic vlen_t word_count(slide_req_t req);
    vlen_t nbytes;
    vlen_t off;
    vlen_t words;
    nbytes = req.vl << req.sew;
    off    = req.stride << req.sew;
    words  = (nbytes + vlen_t'($bits(strb_t) - 1)) >> WORD_SHIFT;
    if (req.op == OP_SLIDEDOWN) begin
      return words;
    end
    // Slide-up skips the words below the offset, or everything
    if (off >= nbytes) begin
      return '0;
    end
    return words - (off >> WORD_SHIFT);
  endfunction

  function automatic logic [PNT_W-1:0] next_pnt(logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  queue_st_t   st_d, st_q;
  slide_req_t  insn_q [DEPTH];
  // Words still to be committed, per entry
  vlen_t       words_q [DEPTH];
  slide_resp_t resp_d, resp_q;

  logic  accept;
  logic  issue_fire;
  logic  head_valid;
  logic  head_issued;
  logic  head_done;
  vlen_t head_left;

  ////////////////////////////////////////////////////////////
  // Accept and issue
  ////////////////////////////////////////////////////////////

  // Full when every entry still waits for its commit
  assign req_ready_o   = (st_q.commit_cnt != CNT_W'(DEPTH));
  assign accept        = req_valid_i && req_ready_o;
  assign issue_valid_o = (st_q.issue_cnt != '0);
  assign issue_req_o   = insn_q[st_q.issue_pnt];
  assign issue_fire    = issue_valid_o && issue_ready_i;

  ////////////////////////////////////////////////////////////
  // Commit
  ////////////////////////////////////////////////////////////

  assign head_valid  = (st_q.commit_cnt != '0);
  // Head left the engine once fewer entries wait for issue than for commit
  assign head_issued = (st_q.issue_cnt < st_q.commit_cnt);
  assign head_left   = words_q[st_q.commit_pnt] - vlen_t'(commit_pop_i);
  assign head_done   = head_valid && head_issued && (head_left == '0);

  always_comb begin
    st_d   = st_q;
    resp_d = '0;
    if (accept) begin
      st_d.accept_pnt = next_pnt(st_q.accept_pnt);
    end
    if (issue_fire) begin
      st_d.issue_pnt = next_pnt(st_q.issue_pnt);
    end
    if (head_done) begin
      st_d.commit_pnt = next_pnt(st_q.commit_pnt);
      resp_d.done     = 1'b1;
      resp_d.id       = insn_q[st_q.commit_pnt].id;
    end
    st_d.issue_cnt  = st_q.issue_cnt + CNT_W'(accept) - CNT_W'(issue_fire);
    st_d.commit_cnt = st_q.commit_cnt + CNT_W'(accept) - CNT_W'(head_done);
  end

  // Entry storage, accept and commit never touch the same slot
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[st_q.accept_pnt]  <= req_i;
      words_q[st_q.accept_pnt] <= word_count(req_i);
    end
    if (head_valid && commit_pop_i) begin
      words_q[st_q.commit_pnt] <= head_left;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q   <= '0;
      resp_q <= '0;
    end else begin
      st_q   <= st_d;
      resp_q <= resp_d;
    end
  end

  // Done is registered, one cycle after the last pop
  assign resp_o = resp_q;

  a_issue_le_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_q.issue_cnt <= st_q.commit_cnt);

endmodule

//--- hw/vrf_pkg.sv
`include "slide_defs.svh"

package vrf_pkg;

  // Word address inside the register file
  typedef logic [`SLIDE_ADDR_W-1:0] vaddr_t;

  // All lanes side by side, byte b sits in lane b/8
  typedef logic [8*`SLIDE_WORD_BYTES-1:0] word_t;

  // One enable per byte of a word
  typedef logic [`SLIDE_WORD_BYTES-1:0] strb_t;

  // Source word read from the lanes
  typedef struct packed {
    word_t data;
  } operand_t;

  // Destination word written back to the lanes
  typedef struct packed {
    vaddr_t addr;
    word_t  wdata;
    strb_t  be;
  } result_t;

endpackage

//--- hw/slide_pkg.sv
`include "slide_defs.svh"

package slide_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////

  // Instruction id as handed out by the sequencer
  typedef logic [$clog2(`SLIDE_NR_VINSN)-1:0] vid_t;

  // Element and byte counts
  typedef logic [`SLIDE_VL_W-1:0] vlen_t;

  typedef enum logic {
    OP_SLIDEUP,
    OP_SLIDEDOWN
  } slide_op_e;

  // Element width, also the log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Slide request from the sequencer
  typedef struct packed {
    vid_t                      id;
    slide_op_e                 op;
    vew_e                      sew;
    vlen_t                     vl;
    // Offset in elements
    vlen_t                     stride;
    // Base word address of the destination
    logic [`SLIDE_ADDR_W-1:0]  vd;
  } slide_req_t;

  // Completion report back to the sequencer
  typedef struct packed {
    logic done;
    vid_t id;
  } slide_resp_t;

endpackage

//--- hw/slide_defs.svh
`ifndef SLIDE_DEFS_SVH
`define SLIDE_DEFS_SVH

// Number of 64-bit lanes
`define SLIDE_NR_LANES 4

// Bytes in one full word across all lanes
`define SLIDE_WORD_BYTES (8 * `SLIDE_NR_LANES)

// Queue depths
`define SLIDE_INSN_DEPTH 4
`define SLIDE_RESULT_DEPTH 2

// Instruction id space
`define SLIDE_NR_VINSN 8

// Register file word address and vector length widths
`define SLIDE_ADDR_W 10
`define SLIDE_VL_W 16

`endif
